// File: list.f
src/asg_regmap_pkg.sv
src/asg_engine_pkg.sv
src/asg_regs.sv
src/asg_buf_arb.sv
src/asg_engine.sv
src/asg_top.sv
tb/asg_tb.sv

// File: Bender.yml
package:
  name: asg

sources:
  - src/asg_regmap_pkg.sv
  - src/asg_engine_pkg.sv
  - src/asg_regs.sv
  - src/asg_buf_arb.sv
  - src/asg_engine.sv
  - src/asg_top.sv
  - target: test
    files:
      - tb/asg_tb.sv

// File: tb/asg_tb.sv
////////////////////
// asg channel testbench
// bus tasks, random stimulus, buffer and pointer model, stream checks
////////////////////

`timescale 1ns/1ps

module asg_tb import asg_regmap_pkg::*, asg_engine_pkg::*;;

  localparam int unsigned DWO = asg_dwo_def;
  localparam int unsigned CWM = 10;
  localparam int unsigned CWF = asg_cwf_def;
  localparam int unsigned CW  = CWM + CWF;
  localparam int unsigned TWA = 4;

  logic                  clk;
  logic                  rstn;
  logic signed [DWO-1:0] sto_dat;
  logic                  sto_vld;
  logic                  sto_rdy;
  logic [TWA-1:0]        trg_ext;
  logic                  trg_swo;
  logic                  trg_out;
  logic                  sys_wen;
  logic                  sys_ren;
  logic [32-1:0]         sys_addr;
  logic [32-1:0]         sys_wdata;
  logic [32-1:0]         sys_rdata;
  logic                  sys_err;
  logic                  sys_ack;

  logic [DWO-1:0] mem_model [0:2**CWM-1];  // mirror of the buffer
  logic [DWO-1:0] exp_q[$];                // expected stream
  logic [DWO-1:0] got_q[$];                // transferred samples
  int             n_chk, n_err, n_tout, trg_cnt, swo_cnt, t0, s0, sel, oth;
  logic [31:0]    size, offs, step, ncyc, rd;
  logic [19:0]    reg_list [5];
  logic [31:0]    reg_mask [5];
  logic [31:0]    reg_val  [5];

  asg_top #(.CWM(CWM), .TWA(TWA)) i_asg_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // stream and trigger monitor, mid cycle so values are settled
  always @(negedge clk) begin
    if (rstn) begin
      if (trg_out) trg_cnt++;
      if (trg_swo) swo_cnt++;  // software strobe, one per ctl write
      if (sto_vld && sto_rdy) got_q.push_back(sto_dat);  // taken at next edge
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_chk++;
    if (exp !== act) begin
      n_err++;
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  ////////////////////
  // bus access
  ////////////////////

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    int n;
    @(posedge clk); #1;
    sys_wen = 1'b1;  // one cycle strobe
    sys_addr = addr;
    sys_wdata = data;
    for (n = 0; n < 50; n++) begin
      @(posedge clk); #1;
      sys_wen = 1'b0;
      if (sys_ack) break;
    end
    if (n == 50) begin
      n_tout++;
      $display("timeout: no bus acknowledge on write to 0x%h", addr);
    end
    check_value("bus_err", 0, sys_err);  // no error responses
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk); #1;
    sys_ren = 1'b1;
    sys_addr = addr;
    for (n = 0; n < 50; n++) begin
      @(posedge clk); #1;
      sys_ren = 1'b0;
      if (sys_ack) break;
    end
    data = sys_rdata;
    if (n == 50) begin
      n_tout++;
      $display("timeout: no bus acknowledge on read from 0x%h", addr);
    end
    check_value("bus_err", 0, sys_err);
  endtask

  function automatic logic [31:0] buf_addr(input int idx);
    return (32'd1 << buf_win_bit) | (idx << 2);  // buffer window, word index
  endfunction

  task automatic load_config(input logic [31:0] sz, input logic [31:0] of, input logic [31:0] st,
                             input logic [31:0] nc, input logic [31:0] mode);
    bus_write({12'h0, reg_size_offs}, sz);
    bus_write({12'h0, reg_offs_offs}, of);
    bus_write({12'h0, reg_step_offs}, st);
    bus_write({12'h0, reg_ncyc_offs}, nc);
    bus_write({12'h0, reg_mode_offs}, mode);  // wrap in bit 2, select below
  endtask

  ////////////////////
  // pointer model
  ////////////////////

  // one sample per read, stop after the read that reaches size
  task automatic build_model(input logic [CW-1:0] of, input logic [CW-1:0] sz,
                             input logic [CW-1:0] st, input logic wrap,
                             input logic [15:0] nc, input int max_n);
    logic [CW:0] ptr;
    logic [CW:0] add;
    logic [15:0] cyc;
    logic        ovf;
    logic        last;
    exp_q.delete();
    ptr = {1'b0, of};
    cyc = '0;
    last = 1'b0;
    while (!last && exp_q.size() < max_n) begin
      exp_q.push_back(mem_model[ptr[CW-1:CWF]]);  // integer part addresses
      add = ptr + {1'b0, st};
      ovf = (add >= {1'b0, sz});
      last = ovf && (!wrap || (nc != 0 && cyc + 16'd1 == nc));  // ncyc 0 endless
      if (ovf && wrap) begin
        cyc = cyc + 16'd1;
        ptr = add - {1'b0, sz};
      end else begin
        ptr = {1'b0, add[CW-1:0]};
      end
    end
  endtask

  // random back pressure optional, then compare the whole burst
  task automatic stream_run(input string name, input logic bp);
    int n;
    for (n = 0; n < 20000; n++) begin
      @(posedge clk); #1;
      sto_rdy = bp ? 1'($urandom % 2) : 1'b1;
      if (got_q.size() >= exp_q.size()) break;
    end
    if (n == 20000) begin
      n_tout++;
      $display("timeout: stream %s stopped after %0d samples", name, got_q.size());
    end
    sto_rdy = 1'b1;
    repeat (10) @(posedge clk);  // no extra samples may follow
    #1;
    check_value({name, "_count"}, exp_q.size(), got_q.size());
    check_value({name, "_vld_end"}, 0, sto_vld);
    foreach (exp_q[i])
      if (i < got_q.size()) check_value({name, "_dat"}, exp_q[i], got_q[i]);
  endtask

  task automatic pulse_line(input int idx);
    @(posedge clk); #1;
    trg_ext[idx] = 1'b1;
    @(posedge clk); #1;
    trg_ext = '0;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int n;
    void'($urandom(32'h8cffcecd));
    {sys_wen, sys_ren, sys_addr, sys_wdata} = '0;
    {n_chk, n_err, n_tout, trg_cnt, swo_cnt} = '0;
    rstn = 1'b0;
    sto_rdy = 1'b1;
    trg_ext = '0;
    repeat (4) @(posedge clk);
    #1 rstn = 1'b1;

    // register readback, masked to field width
    reg_list = '{reg_size_offs, reg_offs_offs, reg_step_offs, reg_ncyc_offs, reg_mode_offs};
    reg_mask = '{32'h3ff_ffff, 32'h3ff_ffff, 32'h3ff_ffff, 32'hffff, 32'h7};
    foreach (reg_list[i]) begin
      reg_val[i] = $urandom;
      bus_write({12'h0, reg_list[i]}, reg_val[i]);
    end
    foreach (reg_list[i]) begin
      bus_read({12'h0, reg_list[i]}, rd);
      check_value("reg_readback", reg_val[i] & reg_mask[i], rd);
    end

    // fill the whole buffer, read back random words
    for (int i = 0; i < 2**CWM; i++) begin
      mem_model[i] = DWO'($urandom);
      bus_write(buf_addr(i), {18'h0, mem_model[i]});
    end
    repeat (32) begin
      n = $urandom_range(0, 2**CWM-1);
      bus_read(buf_addr(n), rd);
      check_value("buf_readback", {18'h0, mem_model[n]}, rd);
    end

    // single pass, software trigger
    size = ($urandom_range(40, 200) << 16) | ($urandom & 32'hffff);
    offs = $urandom % size;
    step = $urandom_range(32'h4000, 32'h3ffff);  // 0.25 up to under 4.0
    load_config(size, offs, step, 0, 0);
    build_model(offs, size, step, 1'b0, 16'd0, 4096);
    got_q.delete();
    t0 = trg_cnt;
    s0 = swo_cnt;
    bus_write({12'h0, reg_ctl_offs}, 32'h2);
    check_value("single_trg_swo", s0 + 1, swo_cnt);
    stream_run("single", 1'b0);
    check_value("single_trg_out", t0 + 1, trg_cnt);

    // wrap mode, few wraps, back pressure
    size = ($urandom_range(16, 64) << 16) | ($urandom & 32'hffff);
    offs = $urandom % size;
    step = $urandom_range(32'h4000, 32'h3ffff);
    ncyc = $urandom_range(1, 3);
    load_config(size, offs, step, ncyc, 32'h4);
    build_model(offs, size, step, 1'b1, ncyc[15:0], 8192);
    got_q.delete();
    bus_write({12'h0, reg_ctl_offs}, 32'h2);
    stream_run("wrap", 1'b1);

    // external trigger select
    sel = $urandom_range(0, TWA-1);
    oth = (sel + $urandom_range(1, TWA-1)) % TWA;  // any other line
    load_config(size, offs, step, 0, sel);
    build_model(offs, size, step, 1'b0, 16'd0, 4096);
    got_q.delete();
    t0 = trg_cnt;
    s0 = swo_cnt;
    pulse_line(oth);
    repeat (20) begin
      @(posedge clk); #1;
      check_value("ext_unsel_vld", 0, sto_vld);
    end
    check_value("ext_unsel_trg_out", t0, trg_cnt);
    pulse_line(sel);
    stream_run("ext_sel", 1'b0);
    check_value("ext_sel_trg_out", t0 + 1, trg_cnt);
    check_value("ext_sel_trg_swo", s0, swo_cnt);  // external lines leave the strobe alone

    // engine reset in an endless wrap run
    load_config(size, offs, step, 0, 32'h4);
    build_model(offs, size, step, 1'b1, 16'd0, 256);
    got_q.delete();
    bus_write({12'h0, reg_ctl_offs}, 32'h2);
    for (n = 0; n < 200; n++) begin
      @(posedge clk); #1;
      if (got_q.size() >= 8) break;
    end
    if (n == 200) begin
      n_tout++;
      $display("timeout: endless run produced no samples before engine reset");
    end
    bus_write({12'h0, reg_ctl_offs}, 32'h1);
    check_value("rst_vld", 0, sto_vld);  // cleared at the write edge
    repeat (10) begin
      @(posedge clk); #1;
      check_value("rst_vld", 0, sto_vld);
    end
    foreach (got_q[i])
      if (i < exp_q.size()) check_value("rst_dat", exp_q[i], got_q[i]);
    n = $urandom_range(0, 2**CWM-1);
    bus_read(buf_addr(n), rd);
    check_value("rst_buf_read", {18'h0, mem_model[n]}, rd);

    $display("checks %0d, errors %0d, timeouts %0d", n_chk, n_err, n_tout);
    if (n_err == 0 && n_tout == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule : asg_tb

// File: src/asg_top.sv
////////////////////
// asg channel top
// register bank, buffer arbiter and generator engine
////////////////////

`timescale 1ns/1ps

module asg_top import asg_engine_pkg::*; #(
  parameter int unsigned DWO = asg_dwo_def,  // sample width
  parameter int unsigned CWM = asg_cwm_def,  // pointer integer width
  parameter int unsigned CWF = asg_cwf_def,  // pointer fraction width
  parameter int unsigned TWA = 4             // external trigger lines
)(
  input  logic                  clk,
  input  logic                  rstn,
  // stream out
  output logic signed [DWO-1:0] sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy,
  // triggers
  input  logic [TWA-1:0]        trg_ext,
  output logic                  trg_swo,
  output logic                  trg_out,
  // system bus
  input  logic                  sys_wen,
  input  logic                  sys_ren,
  input  logic [32-1:0]         sys_addr,
  input  logic [32-1:0]         sys_wdata,
  output logic [32-1:0]         sys_rdata,
  output logic                  sys_err,
  output logic                  sys_ack
);

  // control and configuration
  logic                  ctl_rst;
  logic                  trg_sel;
  logic [CWM+CWF-1:0]    cfg_size;
  logic [CWM+CWF-1:0]    cfg_offs;
  logic [CWM+CWF-1:0]    cfg_step;
  logic [16-1:0]         cfg_ncyc;
  logic                  cfg_wrap;
  // bus side of the buffer
  logic                  bus_req;
  logic                  bus_we;
  logic [CWM-1:0]        bus_addr;
  logic signed [DWO-1:0] bus_wdata;
  logic signed [DWO-1:0] bus_rdata;
  logic                  bus_gnt;
  // engine side of the buffer
  logic                  eng_req;
  logic [CWM-1:0]        eng_addr;
  logic signed [DWO-1:0] eng_rdata;

  asg_regs #(.DWO(DWO), .CWM(CWM), .CWF(CWF), .TWA(TWA)) i_regs (
    .clk, .rstn,
    .sys_wen, .sys_ren, .sys_addr, .sys_wdata, .sys_rdata, .sys_ack, .sys_err,
    .trg_ext, .trg_swo, .trg_sel,
    .ctl_rst, .cfg_size, .cfg_offs, .cfg_step, .cfg_ncyc, .cfg_wrap,
    .bus_req, .bus_we, .bus_addr, .bus_wdata, .bus_rdata, .bus_gnt
  );

  asg_buf_arb #(.DWO(DWO), .CWM(CWM)) i_buf_arb (
    .clk, .rstn,
    .eng_req, .eng_addr, .eng_rdata,
    .bus_req, .bus_we, .bus_addr, .bus_wdata, .bus_rdata, .bus_gnt
  );

  asg_engine #(.DWO(DWO), .CWM(CWM), .CWF(CWF)) i_engine (
    .clk, .rstn,
    .trg_sel, .ctl_rst,
    .cfg_size, .cfg_offs, .cfg_step, .cfg_ncyc, .cfg_wrap,
    .eng_req, .eng_addr, .eng_rdata,
    .sto_dat, .sto_vld, .sto_rdy, .trg_out
  );

endmodule : asg_top

// File: src/asg_engine.sv
////////////////////
// asg generator engine
// fixed point read pointer FSM and the output stream register
////////////////////

`timescale 1ns/1ps

module asg_engine import asg_engine_pkg::*; #(
  parameter int unsigned DWO,  // sample width
  parameter int unsigned CWM,  // pointer integer width
  parameter int unsigned CWF   // pointer fraction width
)(
  input  logic                  clk,
  input  logic                  rstn,
  // control
  input  logic                  trg_sel,
  input  logic                  ctl_rst,
  input  logic [CWM+CWF-1:0]    cfg_size,
  input  logic [CWM+CWF-1:0]    cfg_offs,
  input  logic [CWM+CWF-1:0]    cfg_step,
  input  logic [16-1:0]         cfg_ncyc,
  input  logic                  cfg_wrap,
  // buffer reads
  output logic                  eng_req,
  output logic [CWM-1:0]        eng_addr,
  input  logic signed [DWO-1:0] eng_rdata,
  // stream out
  output logic signed [DWO-1:0] sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy,
  output logic                  trg_out
);

  localparam int unsigned CW = CWM + CWF;

  asg_state_t            sts;
  logic [CW-1:0]         ptr;       // read pointer, int.frac
  logic [CW:0]           ptr_add;   // pointer plus step, carry kept
  logic [CW:0]           ptr_sub;   // wrapped pointer
  logic                  ptr_ovf;   // reached or passed size
  logic [16-1:0]         cyc_cnt;   // wraps done
  logic                  cyc_end;   // this wrap is the last one
  logic                  out_fre;   // output reg empty or being taken
  logic                  rd_pend;   // read data arrives this cycle
  logic                  hld_vld;   // skid word waiting
  logic signed [DWO-1:0] hld_dat;
  logic                  lst_rd;    // read issued now is the final one

  ////////////////////
  // pointer arithmetic
  ////////////////////

  assign ptr_add = {1'b0, ptr} + {1'b0, cfg_step};
  assign ptr_sub = ptr_add - {1'b0, cfg_size};
  assign ptr_ovf = (ptr_add >= {1'b0, cfg_size});
  assign cyc_end = (cfg_ncyc != '0) && (cyc_cnt + 16'd1 == cfg_ncyc);  // ncyc 0 never ends

  assign out_fre  = ~sto_vld | sto_rdy;
  assign eng_req  = (sts == RUN) & out_fre & ~hld_vld;  // never more than one word in flight
  assign eng_addr = ptr[CW-1:CWF];                      // integer part
  assign lst_rd   = eng_req & ptr_ovf & (~cfg_wrap | cyc_end);

  // pointer loaded on trigger, advanced with each read
  always_ff @(posedge clk) begin
    if ((sts == IDLE) & trg_sel)
      ptr <= cfg_offs;
    else if (eng_req)
      ptr <= (ptr_ovf & cfg_wrap) ? ptr_sub[CW-1:0] : ptr_add[CW-1:0];
  end

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn || ctl_rst) begin
      sts     <= IDLE;
      trg_out <= 1'b0;
      cyc_cnt <= '0;
      rd_pend <= 1'b0;
      hld_vld <= 1'b0;
      sto_vld <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      rd_pend <= eng_req;
      case (sts)
        IDLE: if (trg_sel) begin
          sts     <= RUN;
          trg_out <= 1'b1;  // burst start marker
          cyc_cnt <= '0;
        end
        RUN: begin
          if (eng_req & ptr_ovf & cfg_wrap)
            cyc_cnt <= cyc_cnt + 16'd1;
          if (lst_rd)
            sts <= DONE;
        end
        DONE: if (~rd_pend & ~hld_vld & out_fre)
          sts <= IDLE;      // last sample gone
        default: sts <= IDLE;
      endcase
      // output stage, skid word first
      if (out_fre) begin
        if (hld_vld) begin
          sto_vld <= 1'b1;
          hld_vld <= 1'b0;
        end else begin
          sto_vld <= rd_pend;
        end
      end else if (rd_pend) begin
        hld_vld <= 1'b1;    // stalled, park the word
      end
    end
  end

  ////////////////////
  // stream data
  ////////////////////

  always_ff @(posedge clk) begin
    if (out_fre)
      sto_dat <= hld_vld ? hld_dat : eng_rdata;
    if (~out_fre & rd_pend)
      hld_dat <= eng_rdata;  // RAM word would be lost otherwise
  end

endmodule : asg_engine

// File: src/asg_buf_arb.sv
////////////////////
// asg buffer with arbiter
// single port sample RAM shared by the engine (priority) and the bus
////////////////////

`timescale 1ns/1ps

module asg_buf_arb #(
  parameter int unsigned DWO,  // sample width
  parameter int unsigned CWM   // address width, depth 2**CWM
)(
  input  logic                  clk,
  input  logic                  rstn,
  // engine side, read only
  input  logic                  eng_req,
  input  logic [CWM-1:0]        eng_addr,
  output logic signed [DWO-1:0] eng_rdata,
  // bus side
  input  logic                  bus_req,
  input  logic                  bus_we,
  input  logic [CWM-1:0]        bus_addr,
  input  logic signed [DWO-1:0] bus_wdata,
  output logic signed [DWO-1:0] bus_rdata,
  output logic                  bus_gnt
);

  logic signed [DWO-1:0] mem [0:2**CWM-1];  // sample buffer

  logic [CWM-1:0]        ram_addr;
  logic                  ram_en;
  logic                  ram_we;
  logic signed [DWO-1:0] ram_q;     // registered read word
  logic                  own_bus;   // bus owned the port last cycle

  ////////////////////
  // arbitration
  ////////////////////

  // engine always wins, bus waits with its request held
  assign bus_gnt  = bus_req & ~eng_req;
  assign ram_en   = eng_req | bus_req;
  assign ram_addr = eng_req ? eng_addr : bus_addr;
  assign ram_we   = bus_gnt & bus_we;   // only the bus writes

  ////////////////////
  // RAM port
  ////////////////////

  always_ff @(posedge clk) begin
    if (ram_we)
      mem[ram_addr] <= bus_wdata;
    if (ram_en & ~ram_we)
      ram_q <= mem[ram_addr];  // one cycle read latency
  end

  always_ff @(posedge clk) begin
    if (!rstn)
      own_bus <= 1'b0;
    else
      own_bus <= bus_gnt;
  end

  // read word goes to whoever issued the access
  assign eng_rdata = own_bus ? '0 : ram_q;
  assign bus_rdata = own_bus ? ram_q : '0;

endmodule : asg_buf_arb

// File: src/asg_regs.sv
////////////////////
// asg register bank
// system bus decode, configuration, control strobes, trigger select
// and the bus side of buffer access
////////////////////

`timescale 1ns/1ps

module asg_regs import asg_regmap_pkg::*; #(
  parameter int unsigned DWO,  // sample width
  parameter int unsigned CWM,  // pointer integer width
  parameter int unsigned CWF,  // pointer fraction width
  parameter int unsigned TWA   // number of external triggers
)(
  input  logic                      clk,
  input  logic                      rstn,
  // system bus
  input  logic                      sys_wen,
  input  logic                      sys_ren,
  input  logic [32-1:0]             sys_addr,
  input  logic [32-1:0]             sys_wdata,
  output logic [32-1:0]             sys_rdata,
  output logic                      sys_ack,
  output logic                      sys_err,
  // triggers
  input  logic [TWA-1:0]            trg_ext,
  output logic                      trg_swo,   // software strobe
  output logic                      trg_sel,   // combined trigger to engine
  // engine control
  output logic                      ctl_rst,
  output logic [CWM+CWF-1:0]        cfg_size,
  output logic [CWM+CWF-1:0]        cfg_offs,
  output logic [CWM+CWF-1:0]        cfg_step,
  output logic [16-1:0]             cfg_ncyc,
  output logic                      cfg_wrap,
  // buffer access
  output logic                      bus_req,
  output logic                      bus_we,
  output logic [CWM-1:0]            bus_addr,
  output logic signed [DWO-1:0]     bus_wdata,
  input  logic signed [DWO-1:0]     bus_rdata,
  input  logic                      bus_gnt
);

  localparam int unsigned CW  = CWM + CWF;
  localparam int unsigned TWS = (TWA > 1) ? $clog2(TWA) : 1;  // trigger select width

  logic [reg_addr_w-1:0] offs;      // decoded register offset
  logic                  win;       // buffer window hit
  logic                  sys_en;
  logic                  reg_en;    // register access strobe
  logic                  ctl_wen;   // write to control word
  logic [TWS-1:0]        cfg_tsel;
  logic                  trg_mux;   // selected external line
  logic                  rd_dly;    // buffer read data on bus_rdata

  assign offs   = sys_addr[reg_addr_w-1:0];
  assign win    = sys_addr[buf_win_bit];
  assign sys_en = sys_wen | sys_ren;
  assign reg_en = sys_en & ~win;

  assign sys_err = 1'b0;  // no error responses

  ////////////////////
  // configuration
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_tsel <= '0;
      cfg_wrap <= 1'b0;
      cfg_size <= '0;
      cfg_offs <= '0;
      cfg_step <= '0;
      cfg_ncyc <= '0;
    end else if (sys_wen & ~win) begin
      if (offs == reg_mode_offs) begin
        cfg_tsel <= sys_wdata[TWS-1:0];
        cfg_wrap <= sys_wdata[TWS];     // wrap enable right above select
      end
      if (offs == reg_size_offs) cfg_size <= sys_wdata[CW-1:0];
      if (offs == reg_offs_offs) cfg_offs <= sys_wdata[CW-1:0];
      if (offs == reg_step_offs) cfg_step <= sys_wdata[CW-1:0];
      if (offs == reg_ncyc_offs) cfg_ncyc <= sys_wdata[16-1:0];
    end
  end

  // control word bits act only in the write cycle
  assign ctl_wen = sys_wen & ~win & (offs == reg_ctl_offs);
  assign ctl_rst = ctl_wen & sys_wdata[0];
  assign trg_swo = ctl_wen & sys_wdata[1];

  ////////////////////
  // trigger select
  ////////////////////

  assign trg_mux = (cfg_tsel < TWA) ? trg_ext[cfg_tsel] : 1'b0;  // out of range -> none
  assign trg_sel = trg_swo | trg_mux;

  ////////////////////
  // buffer request
  ////////////////////

  // address and data latched on the strobe, held until granted
  always_ff @(posedge clk) begin
    if (sys_en & win) begin
      bus_we    <= sys_wen;
      bus_addr  <= sys_addr[CWM+1:2];  // word index
      bus_wdata <= sys_wdata[DWO-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bus_req <= 1'b0;
      rd_dly  <= 1'b0;
      sys_ack <= 1'b0;
    end else begin
      if (sys_en & win)
        bus_req <= 1'b1;
      else if (bus_gnt)
        bus_req <= 1'b0;
      rd_dly  <= bus_gnt & ~bus_we;
      // reg: 1 after strobe, buf write: 1 after gnt, buf read: 2 after gnt
      sys_ack <= reg_en | (bus_gnt & bus_we) | rd_dly;
    end
  end

  ////////////////////
  // read data
  ////////////////////

  always_ff @(posedge clk) begin
    if (rd_dly) begin
      sys_rdata <= {{(32-DWO){1'b0}}, bus_rdata};  // sample, zero extended
    end else if (sys_ren & ~win) begin
      case (offs)
        reg_mode_offs: sys_rdata <= {{(31-TWS){1'b0}}, cfg_wrap, cfg_tsel};
        reg_size_offs: sys_rdata <= {{(32-CW){1'b0}}, cfg_size};
        reg_offs_offs: sys_rdata <= {{(32-CW){1'b0}}, cfg_offs};
        reg_step_offs: sys_rdata <= {{(32-CW){1'b0}}, cfg_step};
        reg_ncyc_offs: sys_rdata <= {16'h0, cfg_ncyc};
        default:       sys_rdata <= 32'h0;  // ctl reads as zero
      endcase
    end
  end

endmodule : asg_regs

// File: src/asg_engine_pkg.sv
////////////////////
// asg engine definitions
// generator states and default fixed point widths
////////////////////

package asg_engine_pkg;

  // read pointer FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for trigger
    RUN  = 2'd1,  // issuing buffer reads
    DONE = 2'd2   // last read issued, draining the pipeline
  } asg_state_t;

  // default widths
  localparam int unsigned asg_dwo_def = 14;  // sample width
  localparam int unsigned asg_cwm_def = 10;  // pointer integer part, buffer depth 2**cwm
  localparam int unsigned asg_cwf_def = 16;  // pointer fraction part

endpackage : asg_engine_pkg

// File: src/asg_regmap_pkg.sv
////////////////////
// asg register map
// bus offsets of the configuration registers and the buffer window decode
////////////////////

package asg_regmap_pkg;

  // decoded address width, upper bits ignored
  localparam int unsigned reg_addr_w = 20;

  ////////////////////
  // register offsets
  ////////////////////

  localparam logic [reg_addr_w-1:0] reg_ctl_offs  = 20'h00;  // bit0 engine reset, bit1 sw trigger
  localparam logic [reg_addr_w-1:0] reg_mode_offs = 20'h04;  // trigger select, wrap enable
  localparam logic [reg_addr_w-1:0] reg_size_offs = 20'h08;  // buffer size, fixed point
  localparam logic [reg_addr_w-1:0] reg_offs_offs = 20'h0C;  // start offset, fixed point
  localparam logic [reg_addr_w-1:0] reg_step_offs = 20'h10;  // pointer step, fixed point
  localparam logic [reg_addr_w-1:0] reg_ncyc_offs = 20'h18;  // wrap count, 0 = endless

  ////////////////////
  // buffer window
  ////////////////////

  // set -> buffer access, word index from address bits above 2
  localparam int unsigned buf_win_bit = 16;

endpackage : asg_regmap_pkg
